// File: hdl/fetch_ctrl.sv
// fetch control
// pc register, four-phase req/ack master to instruction memory,
// static branch prediction and redirect handling

`default_nettype none

`include "fetch_macros.svh"

module fetch_ctrl (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic [`FE_XLEN-1:0]  boot_addr_i,
    input  logic                 redirect_valid_i,
    input  logic [`FE_XLEN-1:0]  redirect_pc_i,
    input  logic                 imem_ack_i,
    input  logic [`FE_XLEN-1:0]  imem_rdata_i,
    input  logic                 queue_ready_i,
    input  fetch_pkg::cf_e       scan_cf_i,
    input  logic [`FE_XLEN-1:0]  scan_offset_i,
    output logic                 imem_req_o,
    output logic [`FE_XLEN-1:0]  imem_addr_o,
    output fetch_pkg::instr_u    scan_instr_o,
    output logic                 push_valid_o,
    output logic [`FE_XLEN-1:0]  push_pc_o,
    output logic [`FE_XLEN-1:0]  push_instr_o,
    output logic                 push_taken_o,
    output logic [`FE_XLEN-1:0]  push_target_o
);
    import fetch_pkg::*;

    // request fsm encoding
    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_REQ     = 2'd1;
    localparam logic [1:0] ST_ACK_LOW = 2'd2;

    localparam logic [`FE_XLEN-1:0] STEP = `FE_INSTR_BYTES;

    logic [1:0]          state_q, state_d;
    // pc of the next fetch to issue
    logic [`FE_XLEN-1:0] pc_q, pc_d;
    // address of the fetch in flight, held stable on the bus
    logic [`FE_XLEN-1:0] addr_q, addr_d;
    // set out of reset so boot_addr_i gets loaded
    logic                boot_load_q;
    // in-flight fetch was overtaken by a redirect
    logic                kill_q, kill_d;

    logic [`FE_XLEN-1:0] fetch_pc;
    logic [`FE_XLEN-1:0] start_addr;
    logic [`FE_XLEN-1:0] next_pc;
    logic                taken;
    logic                ack_seen;

    // ----------------------------------------------------------
    // static prediction
    // ----------------------------------------------------------
    // backward branch taken, forward not taken, jal always taken
    assign taken = (scan_cf_i == CF_JUMP) ||
                   ((scan_cf_i == CF_BRANCH) && scan_offset_i[`FE_XLEN-1]);

    assign next_pc = addr_q + (taken ? scan_offset_i : STEP);

    // returned word goes straight into the scanner
    assign scan_instr_o = instr_u'(imem_rdata_i);

    // first cycle with ack while requesting
    assign ack_seen = (state_q == ST_REQ) && imem_ack_i;

    // ----------------------------------------------------------
    // pc select
    // ----------------------------------------------------------
    assign fetch_pc   = boot_load_q ? boot_addr_i : pc_q;
    // a redirect in the issue cycle wins over the held pc
    assign start_addr = redirect_valid_i ? redirect_pc_i : fetch_pc;

    always_comb begin
        pc_d = fetch_pc;
        // killed data must not move the pc
        if (ack_seen && !kill_q) begin
            pc_d = next_pc;
        end
        if (redirect_valid_i) begin
            pc_d = redirect_pc_i;
        end
    end

    // ----------------------------------------------------------
    // four-phase request fsm
    // ----------------------------------------------------------
    always_comb begin
        state_d = state_q;
        addr_d  = addr_q;
        kill_d  = kill_q;
        case (state_q)
            ST_IDLE: begin
                // only issue when the queue has room for the result
                if (queue_ready_i) begin
                    state_d = ST_REQ;
                    addr_d  = start_addr;
                end
            end
            ST_REQ: begin
                if (imem_ack_i) begin
                    state_d = ST_ACK_LOW;
                    kill_d  = 1'b0;
                end else if (redirect_valid_i) begin
                    kill_d = 1'b1;
                end
            end
            ST_ACK_LOW: begin
                // new req only once ack is seen low
                if (!imem_ack_i) begin
                    if (queue_ready_i) begin
                        state_d = ST_REQ;
                        addr_d  = start_addr;
                    end else begin
                        state_d = ST_IDLE;
                    end
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= ST_IDLE;
            pc_q        <= '0;
            addr_q      <= '0;
            boot_load_q <= 1'b1;
            kill_q      <= 1'b0;
        end else begin
            state_q     <= state_d;
            pc_q        <= pc_d;
            addr_q      <= addr_d;
            boot_load_q <= 1'b0;
            kill_q      <= kill_d;
        end
    end

    // ----------------------------------------------------------
    // outputs
    // ----------------------------------------------------------
    assign imem_req_o  = (state_q == ST_REQ);
    assign imem_addr_o = addr_q;

    // push on first ack, drop killed data and data racing a redirect
    assign push_valid_o  = ack_seen && !kill_q && !redirect_valid_i;
    assign push_pc_o     = addr_q;
    assign push_instr_o  = imem_rdata_i;
    assign push_taken_o  = taken;
    assign push_target_o = next_pc;

    // req and its address hold until the memory acks
    a_req_hold : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (imem_req_o && !imem_ack_i) |=> (imem_req_o && $stable(imem_addr_o))
    );

    // request was only issued with a free slot, so the push must fit
    a_push_room : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        push_valid_o |-> queue_ready_i
    );

endmodule

`default_nettype wire

// File: hdl/fetch_frontend.sv
// instruction fetch frontend
// single-issue fetch with static prediction, memory req/ack port
// and a fetch queue toward the back-end

`default_nettype none

`include "fetch_macros.svh"

module fetch_frontend (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic [`FE_XLEN-1:0]  boot_addr_i,
    // redirect from the back-end, flushes speculative work
    input  logic                 redirect_valid_i,
    input  logic [`FE_XLEN-1:0]  redirect_pc_i,
    // instruction memory, four-phase handshake
    output logic                 imem_req_o,
    output logic [`FE_XLEN-1:0]  imem_addr_o,
    input  logic                 imem_ack_i,
    input  logic [`FE_XLEN-1:0]  imem_rdata_i,
    // fetch entries toward decode
    output logic                 fetch_valid_o,
    input  logic                 fetch_ready_i,
    output logic [`FE_XLEN-1:0]  fetch_pc_o,
    output logic [`FE_XLEN-1:0]  fetch_instr_o,
    output logic                 fetch_taken_o,
    output logic [`FE_XLEN-1:0]  fetch_target_o
);
    import fetch_pkg::*;

    // scanner path
    instr_u              scan_instr;
    cf_e                 scan_cf;
    logic [`FE_XLEN-1:0] scan_offset;

    // control to queue
    logic                queue_ready;
    logic                push_valid;
    logic [`FE_XLEN-1:0] push_pc;
    logic [`FE_XLEN-1:0] push_instr;
    logic                push_taken;
    logic [`FE_XLEN-1:0] push_target;

    // ----------------------------------------------------------
    // decode: classify the returned word
    // ----------------------------------------------------------
    instr_scan i_instr_scan (
        .instr_i  (scan_instr),
        .cf_o     (scan_cf),
        .offset_o (scan_offset)
    );

    // ----------------------------------------------------------
    // execute: pc, memory master, prediction
    // ----------------------------------------------------------
    fetch_ctrl i_fetch_ctrl (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .boot_addr_i      (boot_addr_i),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .imem_ack_i       (imem_ack_i),
        .imem_rdata_i     (imem_rdata_i),
        .queue_ready_i    (queue_ready),
        .scan_cf_i        (scan_cf),
        .scan_offset_i    (scan_offset),
        .imem_req_o       (imem_req_o),
        .imem_addr_o      (imem_addr_o),
        .scan_instr_o     (scan_instr),
        .push_valid_o     (push_valid),
        .push_pc_o        (push_pc),
        .push_instr_o     (push_instr),
        .push_taken_o     (push_taken),
        .push_target_o    (push_target)
    );

    // ----------------------------------------------------------
    // result: queue toward the back-end
    // ----------------------------------------------------------
    // redirect empties the queue in the same cycle
    fetch_queue i_fetch_queue (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .flush_i        (redirect_valid_i),
        .push_valid_i   (push_valid),
        .push_pc_i      (push_pc),
        .push_instr_i   (push_instr),
        .push_taken_i   (push_taken),
        .push_target_i  (push_target),
        .fetch_ready_i  (fetch_ready_i),
        .queue_ready_o  (queue_ready),
        .fetch_valid_o  (fetch_valid_o),
        .fetch_pc_o     (fetch_pc_o),
        .fetch_instr_o  (fetch_instr_o),
        .fetch_taken_o  (fetch_taken_o),
        .fetch_target_o (fetch_target_o)
    );

endmodule

`default_nettype wire

// File: hdl/fetch_macros.svh
// fetch frontend parameters
// widths, major opcodes and queue sizing shared by the fetch blocks

`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// ----------------------------------------------------------
// datapath
// ----------------------------------------------------------
// width of addresses and instruction words
`define FE_XLEN 32

// byte step between sequential instructions, no compressed support
`define FE_INSTR_BYTES 4

// ----------------------------------------------------------
// major opcodes seen by the scanner
// ----------------------------------------------------------
// conditional branches (beq, bne, blt, ...)
`define FE_OPC_BRANCH 7'b1100011

// direct jump with pc-relative target
`define FE_OPC_JAL 7'b1101111

// ----------------------------------------------------------
// fetch queue
// ----------------------------------------------------------
// entries between fetch and back-end
`define FE_QUEUE_DEPTH 4

`endif

// File: hdl/fetch_pkg.sv
// fetch frontend package
// instruction format views and control-flow classification

`default_nettype none

`include "fetch_macros.svh"

package fetch_pkg;

    // ----------------------------------------------------------
    // instruction formats
    // ----------------------------------------------------------
    // B-format, immediate bits are spread over two fields
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    // J-format, 20-bit immediate in scrambled order
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one fetched word, decoded as branch or as jump
    // opcode sits in the same bits for both views
    typedef union packed {
        b_fmt_t                b;
        j_fmt_t                j;
        logic [`FE_XLEN-1:0]   raw;
    } instr_u;

    // ----------------------------------------------------------
    // control flow classes
    // ----------------------------------------------------------
    // jalr is not classified, it needs a target we don't have
    typedef enum logic [1:0] {
        CF_NONE   = 2'd0,
        CF_BRANCH = 2'd1,
        CF_JUMP   = 2'd2
    } cf_e;

endpackage

`default_nettype wire

// File: hdl/fetch_queue.sv
// fetch queue
// circular FIFO of fetch entries toward the back-end,
// valid/ready on the output side and a same-cycle flush

`default_nettype none

`include "fetch_macros.svh"

module fetch_queue (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 flush_i,
    input  logic                 push_valid_i,
    input  logic [`FE_XLEN-1:0]  push_pc_i,
    input  logic [`FE_XLEN-1:0]  push_instr_i,
    input  logic                 push_taken_i,
    input  logic [`FE_XLEN-1:0]  push_target_i,
    input  logic                 fetch_ready_i,
    output logic                 queue_ready_o,
    output logic                 fetch_valid_o,
    output logic [`FE_XLEN-1:0]  fetch_pc_o,
    output logic [`FE_XLEN-1:0]  fetch_instr_o,
    output logic                 fetch_taken_o,
    output logic [`FE_XLEN-1:0]  fetch_target_o
);
    localparam int DEPTH = `FE_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    // entry storage
    logic [`FE_XLEN-1:0] pc_mem     [DEPTH];
    logic [`FE_XLEN-1:0] instr_mem  [DEPTH];
    logic                taken_mem  [DEPTH];
    logic [`FE_XLEN-1:0] target_mem [DEPTH];

    logic [PTR_W-1:0]    wr_ptr_q;
    logic [PTR_W-1:0]    rd_ptr_q;
    logic [CNT_W-1:0]    count_q;
    logic                full;
    logic                push;
    logic                pop;

    assign full = (count_q == CNT_W'(DEPTH));
    assign push = push_valid_i && !full;
    assign pop  = fetch_valid_o && fetch_ready_i;

    // ----------------------------------------------------------
    // pointers and fill level
    // ----------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            // drop everything queued, speculative path is gone
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // write port
    always_ff @(posedge clk_i) begin
        if (push) begin
            pc_mem[wr_ptr_q]     <= push_pc_i;
            instr_mem[wr_ptr_q]  <= push_instr_i;
            taken_mem[wr_ptr_q]  <= push_taken_i;
            target_mem[wr_ptr_q] <= push_target_i;
        end
    end

    // ----------------------------------------------------------
    // back-end side
    // ----------------------------------------------------------
    assign queue_ready_o  = !full;
    assign fetch_valid_o  = (count_q != '0);
    assign fetch_pc_o     = pc_mem[rd_ptr_q];
    assign fetch_instr_o  = instr_mem[rd_ptr_q];
    assign fetch_taken_o  = taken_mem[rd_ptr_q];
    assign fetch_target_o = target_mem[rd_ptr_q];

    // producer checks the space before it issues a fetch
    a_no_overflow : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        push_valid_i |-> !full
    );

    // the fetch side suppresses its push during a redirect
    a_flush_empty : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        flush_i |=> !fetch_valid_o
    );

endmodule

`default_nettype wire

// File: hdl/instr_scan.sv
// instruction scanner
// classifies a fetched word as branch, jal or other and
// returns its sign-extended pc-relative offset

`default_nettype none

`include "fetch_macros.svh"

module instr_scan (
    input  fetch_pkg::instr_u    instr_i,
    output fetch_pkg::cf_e       cf_o,
    output logic [`FE_XLEN-1:0]  offset_o
);
    import fetch_pkg::*;

    // reassembled immediates, already sign extended
    logic [`FE_XLEN-1:0] b_imm;
    logic [`FE_XLEN-1:0] j_imm;
    // opcode match flags
    logic                is_branch;
    logic                is_jal;

    // ----------------------------------------------------------
    // opcode match
    // ----------------------------------------------------------
    // both views share bits 6:0, the B view is used for the test
    assign is_branch = (instr_i.b.opcode == `FE_OPC_BRANCH);
    assign is_jal    = (instr_i.j.opcode == `FE_OPC_JAL);

    // ----------------------------------------------------------
    // immediate reassembly
    // ----------------------------------------------------------
    // branch offset: imm[12|10:5|4:1|11], bit 0 always zero
    assign b_imm = {
        {(`FE_XLEN - 13){instr_i.b.imm12}},
        instr_i.b.imm12,
        instr_i.b.imm11,
        instr_i.b.imm10_5,
        instr_i.b.imm4_1,
        1'b0
    };

    // jal offset: imm[20|10:1|11|19:12], bit 0 always zero
    assign j_imm = {
        {(`FE_XLEN - 21){instr_i.j.imm20}},
        instr_i.j.imm20,
        instr_i.j.imm19_12,
        instr_i.j.imm11,
        instr_i.j.imm10_1,
        1'b0
    };

    // ----------------------------------------------------------
    // classification
    // ----------------------------------------------------------
    always_comb begin
        // default: plain instruction, no offset
        cf_o     = CF_NONE;
        offset_o = '0;
        if (is_branch) begin
            cf_o     = CF_BRANCH;
            offset_o = b_imm;
        end else if (is_jal) begin
            cf_o     = CF_JUMP;
            offset_o = j_imm;
        end
    end

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# build and run the fetch frontend testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f sim.f --top-module tb_fetch_frontend --Mdir obj_dir \
    && ./obj_dir/Vtb_fetch_frontend > sim.log 2>&1 \
    || echo "build or simulation did not complete"

cat sim.log 2>/dev/null
grep -qx "NO ERRORS" sim.log && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }

// File: sim.f
+incdir+hdl
hdl/fetch_pkg.sv
hdl/instr_scan.sv
hdl/fetch_ctrl.sv
hdl/fetch_queue.sv
hdl/fetch_frontend.sv
verification/tb_fetch_frontend.sv

// File: verification/tb_fetch_frontend.sv
// fetch frontend testbench
// LFSR-filled memory behind a four-phase responder, random back-pressure
// and redirects with each accepted entry checked against a next-pc model

`default_nettype none

`include "fetch_macros.svh"

module tb_fetch_frontend;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] BOOT_ADDR     = 32'h8000_0100;
    localparam logic [31:0] REDIRECT_BASE = 32'h8000_0000;
    localparam int          TOTAL_ENTRIES = 64 + 96 + 128;
    localparam int          CYCLE_LIMIT   = 40 * TOTAL_ENTRIES;
    // word kinds stored next to each memory word for the model
    localparam logic [1:0]  K_OTHER  = 2'd0;
    localparam logic [1:0]  K_BRANCH = 2'd1;
    localparam logic [1:0]  K_JAL    = 2'd2;
    // memory responder states
    localparam logic [1:0]  M_IDLE = 2'd0;
    localparam logic [1:0]  M_WAIT = 2'd1;
    localparam logic [1:0]  M_ACK  = 2'd2;
    // op-imm, op, load and jalr are never predicted as control flow
    localparam logic [6:0]  OTHER_OPC [4] = '{7'b0010011, 7'b0110011, 7'b0000011, 7'b1100111};

    logic                clk_i;
    logic                rst_ni;
    logic [`FE_XLEN-1:0] boot_addr_i;
    logic                redirect_valid_i;
    logic [`FE_XLEN-1:0] redirect_pc_i;
    logic                imem_req_o;
    logic [`FE_XLEN-1:0] imem_addr_o;
    logic                imem_ack_i;
    logic [`FE_XLEN-1:0] imem_rdata_i;
    logic                fetch_valid_o;
    logic                fetch_ready_i;
    logic [`FE_XLEN-1:0] fetch_pc_o;
    logic [`FE_XLEN-1:0] fetch_instr_o;
    logic                fetch_taken_o;
    logic [`FE_XLEN-1:0] fetch_target_o;

    // memory image indexed by address bits 9:2
    logic [31:0] mem_word [256];
    logic [31:0] mem_off  [256];
    logic [1:0]  mem_kind [256];

    logic [31:0] lfsr_q;
    logic [1:0]  mem_state;
    logic [31:0] wait_left;
    // model state
    logic [31:0] exp_pc;
    logic        flush_check;
    logic        first_req_done;
    logic        req_prev;
    logic        ack_prev;
    logic [31:0] addr_prev;
    // stimulus mode of the running test
    int          ready_mode;
    logic        redirect_on;
    // counters
    int          err_count;
    int          entry_count;
    int          test_entries;
    int          test_taken;
    int          tests_run;
    int          cycle_count;
    int          n_back_taken;
    int          n_fwd;
    int          n_jal;

    fetch_frontend DUT (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .boot_addr_i      (boot_addr_i),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .imem_req_o       (imem_req_o),
        .imem_addr_o      (imem_addr_o),
        .imem_ack_i       (imem_ack_i),
        .imem_rdata_i     (imem_rdata_i),
        .fetch_valid_o    (fetch_valid_o),
        .fetch_ready_i    (fetch_ready_i),
        .fetch_pc_o       (fetch_pc_o),
        .fetch_instr_o    (fetch_instr_o),
        .fetch_taken_o    (fetch_taken_o),
        .fetch_target_o   (fetch_target_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // ----------------------------------------------------------
    // random source and instruction encoding
    // ----------------------------------------------------------
    // fibonacci lfsr x^32+x^22+x^2+x+1 stepped once per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    // regs holds rs2, rs1 and funct3
    function automatic logic [31:0] encode_branch(input logic [31:0] off,
                                                  input logic [12:0] regs);
        return {off[12], off[10:5], regs[12:8], regs[7:3], regs[2:0],
                off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] encode_jal(input logic [31:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // offsets of 1 to 8 words with jal in both directions
    task automatic fill_memory();
        int          i;
        logic [2:0]  sel;
        logic [31:0] mag;
        logic [31:0] off;
        logic [24:0] hi;
        logic [6:0]  opc;
        for (i = 0; i < 256; i++) begin
            sel = 3'(take_bits(3));
            mag = (take_bits(3) + 32'd1) << 2;
            off = (take_bits(1) != 0) ? 32'd0 - mag : mag;
            if (sel == 3'd4 || sel == 3'd5) begin
                off         = (sel == 3'd5) ? 32'd0 - mag : mag;
                mem_kind[i] = K_BRANCH;
                mem_off[i]  = off;
                mem_word[i] = encode_branch(off, 13'(take_bits(13)));
            end else if (sel == 3'd6) begin
                mem_kind[i] = K_JAL;
                mem_off[i]  = off;
                mem_word[i] = encode_jal(off, 5'(take_bits(5)));
            end else begin
                hi          = 25'(take_bits(25));
                opc         = OTHER_OPC[2'(take_bits(2))];
                mem_kind[i] = K_OTHER;
                mem_off[i]  = '0;
                mem_word[i] = {hi, opc};
            end
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("mismatch at %0t: %s got %08h expected %08h", $time, name, got, exp);
        err_count++;
    endtask

    task automatic report_failure(input string msg);
        $display("error at %0t: %s", $time, msg);
        err_count++;
    endtask

    // ----------------------------------------------------------
    // falling-edge drivers
    // ----------------------------------------------------------
    // four-phase slave waiting 0 to 3 cycles before each ack
    task automatic respond_memory();
        if (mem_state == M_IDLE && imem_req_o) begin
            wait_left = take_bits(2);
            mem_state = M_WAIT;
        end
        if (mem_state == M_WAIT) begin
            if (wait_left == 0) begin
                imem_ack_i   = 1'b1;
                imem_rdata_i = mem_word[imem_addr_o[9:2]];
                mem_state    = M_ACK;
            end else begin
                wait_left = wait_left - 1;
            end
        end else if (mem_state == M_ACK && !imem_req_o) begin
            imem_ack_i = 1'b0;
            mem_state  = M_IDLE;
        end
    endtask

    task automatic drive_cycle();
        respond_memory();
        // the back-end accepts nothing in the cycle it redirects
        if (redirect_on && take_bits(4) == 0) begin
            redirect_valid_i = 1'b1;
            redirect_pc_i    = REDIRECT_BASE + (take_bits(8) << 2);
            fetch_ready_i    = 1'b0;
        end else begin
            redirect_valid_i = 1'b0;
            case (ready_mode)
                0:       fetch_ready_i = 1'b1;
                1:       fetch_ready_i = (take_bits(3) == 0);
                default: fetch_ready_i = (take_bits(1) != 0);
            endcase
        end
    endtask

    // ----------------------------------------------------------
    // next-pc model
    // ----------------------------------------------------------
    task automatic check_entry();
        logic [7:0]  idx;
        logic        exp_taken;
        logic [31:0] exp_target;
        idx        = exp_pc[9:2];
        // backward branch and jal are taken and everything else falls through
        exp_taken  = (mem_kind[idx] == K_JAL) ||
                     (mem_kind[idx] == K_BRANCH && mem_off[idx][31]);
        exp_target = exp_pc + (exp_taken ? mem_off[idx] : 32'd4);
        if (fetch_pc_o !== exp_pc)
            report_mismatch("fetch_pc_o", fetch_pc_o, exp_pc);
        if (fetch_instr_o !== mem_word[idx])
            report_mismatch("fetch_instr_o", fetch_instr_o, mem_word[idx]);
        if (fetch_taken_o !== exp_taken)
            report_mismatch("fetch_taken_o", {31'd0, fetch_taken_o}, {31'd0, exp_taken});
        if (fetch_target_o !== exp_target)
            report_mismatch("fetch_target_o", fetch_target_o, exp_target);
        if (mem_kind[idx] == K_JAL)
            n_jal++;
        else if (mem_kind[idx] == K_BRANCH && exp_taken)
            n_back_taken++;
        else if (mem_kind[idx] == K_BRANCH)
            n_fwd++;
        if (exp_taken)
            test_taken++;
        test_entries++;
        entry_count++;
        exp_pc = exp_target;
    endtask

    // sampled on the rising edge after the inputs settled at the falling edge
    always @(posedge clk_i) begin
        if (!rst_ni) begin
            if (imem_req_o !== 1'b0)
                report_failure("imem_req_o high during reset");
            if (fetch_valid_o !== 1'b0)
                report_failure("fetch_valid_o high during reset");
        end else begin
            // four-phase order, judged on the ack seen at the edge req changed
            if (req_prev && !ack_prev && !imem_req_o)
                report_failure("imem_req_o dropped before imem_ack_i was seen");
            if (!req_prev && imem_req_o && ack_prev)
                report_failure("new request raised while imem_ack_i was still high");
            if (req_prev && !ack_prev && imem_req_o && imem_addr_o !== addr_prev)
                report_mismatch("imem_addr_o", imem_addr_o, addr_prev);
            if (imem_req_o && !first_req_done) begin
                first_req_done = 1'b1;
                if (imem_addr_o !== BOOT_ADDR)
                    report_mismatch("imem_addr_o", imem_addr_o, BOOT_ADDR);
            end
            // queue must be empty the cycle after a redirect
            if (flush_check && fetch_valid_o)
                report_failure("entry queued before a redirect reached the back-end");
            if (fetch_valid_o && fetch_ready_i)
                check_entry();
            if (redirect_valid_i)
                exp_pc = redirect_pc_i;
            flush_check = redirect_valid_i;
            req_prev    = imem_req_o;
            ack_prev    = imem_ack_i;
            addr_prev   = imem_addr_o;
        end
    end

    // ----------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------
    task automatic run_test(input string name, input int n, input int mode, input logic redir);
        int err_start;
        err_start    = err_count;
        test_entries = 0;
        test_taken   = 0;
        ready_mode   = mode;
        redirect_on  = redir;
        while (test_entries < n) begin
            @(negedge clk_i);
            drive_cycle();
        end
        tests_run++;
        $display("test %s done: %0d entries, %0d taken, %0d errors",
                 name, test_entries, test_taken, err_count - err_start);
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("timeout: stopped after %0d cycles with %0d of %0d entries checked",
                 cycle_count, entry_count, TOTAL_ENTRIES);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        rst_ni           = 1'b0;
        boot_addr_i      = BOOT_ADDR;
        redirect_valid_i = 1'b0;
        redirect_pc_i    = '0;
        imem_ack_i       = 1'b0;
        imem_rdata_i     = '0;
        fetch_ready_i    = 1'b0;
        lfsr_q           = 32'hd58eec0d;
        mem_state        = M_IDLE;
        wait_left        = '0;
        flush_check      = 1'b0;
        first_req_done   = 1'b0;
        req_prev         = 1'b0;
        ack_prev         = 1'b0;
        addr_prev        = '0;
        ready_mode       = 0;
        redirect_on      = 1'b0;
        err_count        = 0;
        entry_count      = 0;
        test_entries     = 0;
        test_taken       = 0;
        tests_run        = 0;
        n_back_taken     = 0;
        n_fwd            = 0;
        n_jal            = 0;
        fill_memory();
        exp_pc = BOOT_ADDR;

        repeat (10) @(negedge clk_i);
        tests_run++;
        $display("test reset done: %0d errors", err_count);
        rst_ni = 1'b1;

        run_test("boot_stream", 64, 0, 1'b0);
        run_test("back_pressure", 96, 1, 1'b0);
        run_test("redirect", 128, 2, 1'b1);

        if (n_back_taken == 0 || n_fwd == 0 || n_jal == 0)
            report_failure("backward branch, forward branch or jal never reached the back-end");
        $display("summary: %0d tests, %0d entries checked, %0d errors",
                 tests_run, entry_count, err_count);
        if (err_count == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire
